/* Makefile */
# Verilator build and run of the shared test DRAM testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_test_dram
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
src/cache_dma_pkg.sv
src/dram_cfg_pkg.sv
src/dram_chan_if.sv
src/dma_channel_arbiter.sv
src/test_dram_model.sv
src/dma_read_router.sv
src/dma_test_dram_top.sv
verification/tb_dma_test_dram.sv

/* src/cache_dma_pkg.sv */
// cache-side DMA constants shared by the arbiter, the read router and the top level
package cache_dma_pkg;

  // peer vcache ports sharing the channel
  localparam int NUM_CACHES = 4;
  localparam int CACHE_ID_WIDTH = 2;

  // one DMA block is a short burst of full words
  localparam int BLOCK_WORDS = 4;
  localparam int WORD_OFFSET_WIDTH = 2;
  localparam int DATA_WIDTH = 32;

  // cache-local byte address: block index, word offset, 2 byte bits
  localparam int BANK_ADDR_WIDTH = 12;
  localparam int BLOCK_IDX_WIDTH = BANK_ADDR_WIDTH - WORD_OFFSET_WIDTH - 2;

endpackage

/* src/dma_channel_arbiter.sv */
// round-robin arbiter that locks onto one cache packet and issues its block as word commands
module dma_channel_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   pkt_v_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   pkt_write_not_read_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::BANK_ADDR_WIDTH-1:0] pkt_addr_i,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   pkt_ready_o,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   wdata_v_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   wdata_ready_o,
  dram_cmd_if.master                                             cmd
);
  import cache_dma_pkg::*;
  import dram_cfg_pkg::*;

  logic                         run_r;
  logic                         locked_r;
  logic [CACHE_ID_WIDTH-1:0]    lock_id_r;
  logic [CACHE_ID_WIDTH-1:0]    ptr_r;
  logic [WORD_OFFSET_WIDTH-1:0] word_cnt_r;
  logic                         wnr_r;
  logic [BLOCK_IDX_WIDTH-1:0]   block_r;

  logic [CACHE_ID_WIDTH-1:0]    cand_id;
  logic [CACHE_ID_WIDTH-1:0]    grant_id;
  logic                         grant_found;
  logic                         grant;
  logic                         xfer;
  dram_ch_addr_u                cmd_addr;

  // first requester at or after the pointer; walking down lets the nearest one win
  always_comb begin
    grant_found = 1'b0;
    grant_id = ptr_r;
    cand_id = ptr_r;
    for (int k = NUM_CACHES - 1; k >= 0; k--) begin
      cand_id = ptr_r + CACHE_ID_WIDTH'(k);
      if (pkt_v_i[cand_id]) begin
        grant_found = 1'b1;
        grant_id = cand_id;
      end
    end
  end

  assign grant = run_r && !locked_r && grant_found;

  always_comb begin
    pkt_ready_o = '0;
    if (grant) begin
      pkt_ready_o[grant_id] = 1'b1;
    end
  end

  // a write beat moves together with its command
  always_comb begin
    wdata_ready_o = '0;
    if (locked_r && wnr_r && cmd.ready) begin
      wdata_ready_o[lock_id_r] = 1'b1;
    end
  end

  always_comb begin
    cmd_addr.cache.cache_id = lock_id_r;
    cmd_addr.cache.block = block_r;
    cmd_addr.cache.word = word_cnt_r;
    cmd_addr.cache.byte_offset = '0;
  end

  assign cmd.valid = locked_r && (!wnr_r || wdata_v_i[lock_id_r]);
  assign cmd.write_not_read = wnr_r;
  assign cmd.ch_addr = cmd_addr;
  assign cmd.wdata = wdata_i[lock_id_r];
  assign xfer = cmd.valid && cmd.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      run_r <= 1'b0;
      locked_r <= 1'b0;
      lock_id_r <= '0;
      ptr_r <= '0;
      word_cnt_r <= '0;
    end else begin
      run_r <= 1'b1;
      if (grant) begin
        locked_r <= 1'b1;
        lock_id_r <= grant_id;
        ptr_r <= grant_id + CACHE_ID_WIDTH'(1);
        word_cnt_r <= '0;
      end else if (xfer) begin
        word_cnt_r <= word_cnt_r + WORD_OFFSET_WIDTH'(1);
        if (word_cnt_r == WORD_OFFSET_WIDTH'(BLOCK_WORDS - 1)) begin
          locked_r <= 1'b0;
        end
      end
    end
  end

  // packet fields, low address bits dropped
  always_ff @(posedge clk_i) begin
    if (grant) begin
      wnr_r <= pkt_write_not_read_i[grant_id];
      block_r <= pkt_addr_i[grant_id][BANK_ADDR_WIDTH-1 -: BLOCK_IDX_WIDTH];
    end
  end

  a_one_pkt_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(pkt_ready_o))
    else $error("more than one packet grant");

endmodule

/* src/dma_read_router.sv */
// steers each in-order read word from the test DRAM to the cache port that owns its address
module dma_read_router (
  dram_rd_if.sink                                                rd,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   rdata_ready_i,
  output logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::DATA_WIDTH-1:0] rdata_o,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   rdata_v_o
);
  import cache_dma_pkg::*;
  import dram_cfg_pkg::*;

  logic [CACHE_ID_WIDTH-1:0] dst_id;

  // cache id sits in the top bits of the returned channel address
  assign dst_id = rd.ch_addr.cache.cache_id;

  for (genvar i = 0; i < NUM_CACHES; i++) begin : g_port
    assign rdata_o[i] = rd.data;
    assign rdata_v_o[i] = rd.valid && (dst_id == CACHE_ID_WIDTH'(i));
  end

  // one stalled cache holds the head, and with it every other port
  assign rd.ready = rdata_ready_i[dst_id];

  a_rd_stable: assert property (@(posedge rd.clk_i) disable iff (!rd.arst_n_i)
    (rd.valid && !rd.ready) |=> ($stable(rd.data) && $stable(rd.ch_addr)))
    else $error("read return changed while stalled");

endmodule

/* src/dma_test_dram_top.sv */
// shared test DRAM channel for several vcache DMA ports: arbiter, banked model and read router
module dma_test_dram_top (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,

  // block packets
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_pkt_v_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_pkt_write_not_read_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::BANK_ADDR_WIDTH-1:0] dma_pkt_addr_i,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_pkt_ready_o,

  // writeback data
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_wdata_v_i,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::DATA_WIDTH-1:0] dma_wdata_i,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_wdata_ready_o,

  // fill data
  output logic [cache_dma_pkg::NUM_CACHES-1:0][cache_dma_pkg::DATA_WIDTH-1:0] dma_rdata_o,
  output logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_rdata_v_o,
  input  logic [cache_dma_pkg::NUM_CACHES-1:0]                   dma_rdata_ready_i
);

  dram_cmd_if cmd_if ();

  dram_rd_if rd_if (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i)
  );

  dma_channel_arbiter arb (
    .clk_i                (clk_i),
    .arst_n_i             (arst_n_i),
    .pkt_v_i              (dma_pkt_v_i),
    .pkt_write_not_read_i (dma_pkt_write_not_read_i),
    .pkt_addr_i           (dma_pkt_addr_i),
    .pkt_ready_o          (dma_pkt_ready_o),
    .wdata_v_i            (dma_wdata_v_i),
    .wdata_i              (dma_wdata_i),
    .wdata_ready_o        (dma_wdata_ready_o),
    .cmd                  (cmd_if.master)
  );

  test_dram_model dram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .cmd      (cmd_if.slave),
    .rd       (rd_if.source)
  );

  dma_read_router router (
    .rd            (rd_if.sink),
    .rdata_ready_i (dma_rdata_ready_i),
    .rdata_o       (dma_rdata_o),
    .rdata_v_o     (dma_rdata_v_o)
  );

endmodule

/* src/dram_cfg_pkg.sv */
// test DRAM geometry, timing and the channel address word seen by both sides of the channel
package dram_cfg_pkg;

  localparam int BYTE_OFFSET_WIDTH = 2;
  localparam int COL_WIDTH = 4;
  localparam int BANK_WIDTH = 2;
  localparam int ROW_WIDTH = 6;
  localparam int CH_ADDR_WIDTH = ROW_WIDTH + BANK_WIDTH + COL_WIDTH + BYTE_OFFSET_WIDTH;

  localparam int NUM_BANKS = 1 << BANK_WIDTH;
  localparam int MEM_IDX_WIDTH = CH_ADDR_WIDTH - BYTE_OFFSET_WIDTH;
  localparam int MEM_WORDS = 1 << MEM_IDX_WIDTH;

  // timing
  localparam int READ_LATENCY = 4;
  localparam int ROW_MISS_CYCLES = 3;
  localparam int MISS_CNT_WIDTH = 2;

  // return fifo and its credit counter
  localparam int RD_FIFO_DEPTH = 8;
  localparam int RD_FIFO_PTR_WIDTH = 3;
  localparam int RD_CREDIT_WIDTH = 4;

  // dram view for the memory, cache view for the arbiter and router
  typedef union packed {
    struct packed {
      logic [ROW_WIDTH-1:0]         row;
      logic [BANK_WIDTH-1:0]        bank;
      logic [COL_WIDTH-1:0]         col;
      logic [BYTE_OFFSET_WIDTH-1:0] byte_offset;
    } dram;
    struct packed {
      logic [cache_dma_pkg::CACHE_ID_WIDTH-1:0]    cache_id;
      logic [cache_dma_pkg::BLOCK_IDX_WIDTH-1:0]   block;
      logic [cache_dma_pkg::WORD_OFFSET_WIDTH-1:0] word;
      logic [BYTE_OFFSET_WIDTH-1:0]                byte_offset;
    } cache;
  } dram_ch_addr_u;

endpackage

/* src/dram_chan_if.sv */
// command and read-return channels of the shared test DRAM, with valid/ready handshakes
interface dram_cmd_if;
  import cache_dma_pkg::*;
  import dram_cfg_pkg::*;

  logic                  valid;
  logic                  ready;
  logic                  write_not_read;
  dram_ch_addr_u         ch_addr;
  logic [DATA_WIDTH-1:0] wdata;

  modport master (
    output valid,
    output write_not_read,
    output ch_addr,
    output wdata,
    input  ready
  );

  modport slave (
    input  valid,
    input  write_not_read,
    input  ch_addr,
    input  wdata,
    output ready
  );

endinterface

// read words come back in order, tagged with their channel address
interface dram_rd_if (
  input logic clk_i,
  input logic arst_n_i
);
  import cache_dma_pkg::*;
  import dram_cfg_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [DATA_WIDTH-1:0] data;
  dram_ch_addr_u         ch_addr;

  modport source (
    output valid,
    output data,
    output ch_addr,
    input  ready
  );

  // clock and reset are only needed by the consumer's protocol check
  modport sink (
    input  clk_i,
    input  arst_n_i,
    input  valid,
    input  data,
    input  ch_addr,
    output ready
  );

endinterface

/* src/test_dram_model.sv */
// banked test DRAM with one open row per bank, a fixed read pipeline and an in-order return FIFO
module test_dram_model (
  input  logic       clk_i,
  input  logic       arst_n_i,
  dram_cmd_if.slave  cmd,
  dram_rd_if.source  rd
);
  import cache_dma_pkg::*;
  import dram_cfg_pkg::*;

  logic [DATA_WIDTH-1:0]        mem_r [MEM_WORDS];
  logic [ROW_WIDTH-1:0]         open_row_r [NUM_BANKS];
  logic [NUM_BANKS-1:0]         open_v_r;
  logic [MISS_CNT_WIDTH-1:0]    miss_cnt_r;

  logic [READ_LATENCY-1:0]      pipe_v_r;
  logic [DATA_WIDTH-1:0]        pipe_data_r [READ_LATENCY];
  dram_ch_addr_u                pipe_addr_r [READ_LATENCY];

  logic [DATA_WIDTH-1:0]        fifo_data_r [RD_FIFO_DEPTH];
  dram_ch_addr_u                fifo_addr_r [RD_FIFO_DEPTH];
  logic [RD_FIFO_PTR_WIDTH-1:0] wr_ptr_r;
  logic [RD_FIFO_PTR_WIDTH-1:0] rd_ptr_r;
  logic [RD_CREDIT_WIDTH-1:0]   fifo_cnt_r;
  logic [RD_CREDIT_WIDTH-1:0]   credit_r;

  logic [MEM_IDX_WIDTH-1:0]     cmd_idx;
  logic                         row_hit;
  logic                         miss_done;
  logic                         credit_ok;
  logic                         accept;
  logic                         accept_rd;
  logic                         push;
  logic                         pop;

  assign cmd_idx = {cmd.ch_addr.dram.row, cmd.ch_addr.dram.bank, cmd.ch_addr.dram.col};
  assign row_hit = open_v_r[cmd.ch_addr.dram.bank]
                && (open_row_r[cmd.ch_addr.dram.bank] == cmd.ch_addr.dram.row);
  assign miss_done = cmd.valid && !row_hit
                  && (miss_cnt_r == MISS_CNT_WIDTH'(ROW_MISS_CYCLES - 1));

  // fifo entries plus reads in the pipe may not exceed the fifo
  assign credit_ok = credit_r < RD_CREDIT_WIDTH'(RD_FIFO_DEPTH);
  assign cmd.ready = row_hit && credit_ok;
  assign accept = cmd.valid && cmd.ready;
  assign accept_rd = accept && !cmd.write_not_read;

  assign push = pipe_v_r[READ_LATENCY-1];
  assign rd.valid = fifo_cnt_r != '0;
  assign rd.data = fifo_data_r[rd_ptr_r];
  assign rd.ch_addr = fifo_addr_r[rd_ptr_r];
  assign pop = rd.valid && rd.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      open_v_r <= '0;
      miss_cnt_r <= '0;
      pipe_v_r <= '0;
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      fifo_cnt_r <= '0;
      credit_r <= '0;
    end else begin
      // row activation penalty
      if (miss_done) begin
        miss_cnt_r <= '0;
        open_v_r[cmd.ch_addr.dram.bank] <= 1'b1;
      end else if (cmd.valid && !row_hit) begin
        miss_cnt_r <= miss_cnt_r + MISS_CNT_WIDTH'(1);
      end
      pipe_v_r <= {pipe_v_r[READ_LATENCY-2:0], accept_rd};
      wr_ptr_r <= wr_ptr_r + RD_FIFO_PTR_WIDTH'(push);
      rd_ptr_r <= rd_ptr_r + RD_FIFO_PTR_WIDTH'(pop);
      fifo_cnt_r <= fifo_cnt_r + RD_CREDIT_WIDTH'(push) - RD_CREDIT_WIDTH'(pop);
      credit_r <= credit_r + RD_CREDIT_WIDTH'(accept_rd) - RD_CREDIT_WIDTH'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (miss_done) begin
      open_row_r[cmd.ch_addr.dram.bank] <= cmd.ch_addr.dram.row;
    end
    if (accept && cmd.write_not_read) begin
      mem_r[cmd_idx] <= cmd.wdata;
    end
    // read data is sampled at acceptance so later writes cannot overtake it
    pipe_data_r[0] <= mem_r[cmd_idx];
    pipe_addr_r[0] <= cmd.ch_addr;
    for (int k = 1; k < READ_LATENCY; k++) begin
      pipe_data_r[k] <= pipe_data_r[k-1];
      pipe_addr_r[k] <= pipe_addr_r[k-1];
    end
    if (push) begin
      fifo_data_r[wr_ptr_r] <= pipe_data_r[READ_LATENCY-1];
      fifo_addr_r[wr_ptr_r] <= pipe_addr_r[READ_LATENCY-1];
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push |-> (fifo_cnt_r != RD_CREDIT_WIDTH'(RD_FIFO_DEPTH)))
    else $error("return fifo pushed while full");

endmodule

/* verification/tb_dma_test_dram.sv */
// self-checking testbench for the shared test DRAM channel, run as the top module in simulation
module tb_dma_test_dram;
  timeunit 1ns;
  timeprecision 1ps;
  import cache_dma_pkg::*;

  localparam int CLK_HALF = 4;
  localparam int RESET_CYCLES = 16;
  localparam int SAMPLE_DELAY = 1;
  localparam int WAIT_LIMIT = 2000;
  localparam int JOB_LIMIT = 40000;
  localparam int FAIR_PACKETS = 6;
  localparam int RANDOM_ROUNDS = 10;
  localparam int JOB_SAME_WRITE = 0;
  localparam int JOB_SAME_READ = 1;
  localparam int JOB_FAIR = 2;
  localparam int JOB_RANDOM = 3;
  localparam logic [BLOCK_IDX_WIDTH-1:0] SHARED_BLOCK = 8'h3a;

  logic                                   clk_i;
  logic                                   arst_n_i;
  logic [NUM_CACHES-1:0]                  dma_pkt_v_i;
  logic [NUM_CACHES-1:0]                  dma_pkt_write_not_read_i;
  logic [NUM_CACHES-1:0][BANK_ADDR_WIDTH-1:0] dma_pkt_addr_i;
  logic [NUM_CACHES-1:0]                  dma_pkt_ready_o;
  logic [NUM_CACHES-1:0]                  dma_wdata_v_i;
  logic [NUM_CACHES-1:0][DATA_WIDTH-1:0]  dma_wdata_i;
  logic [NUM_CACHES-1:0]                  dma_wdata_ready_o;
  logic [NUM_CACHES-1:0][DATA_WIDTH-1:0]  dma_rdata_o;
  logic [NUM_CACHES-1:0]                  dma_rdata_v_o;
  logic [NUM_CACHES-1:0]                  dma_rdata_ready_i;

  // expected memory, keyed by cache id, block and word
  logic [DATA_WIDTH-1:0] ref_mem [int];
  logic [DATA_WIDTH-1:0] exp_q [NUM_CACHES][$];
  int                    jobs_running;
  bit                    bp_run;
  bit                    rr_check_en;
  int                    rr_seen [NUM_CACHES][NUM_CACHES];
  bit                    rr_granted [NUM_CACHES];
  int                    rr_grants;

  dma_test_dram_top UUT (
    .clk_i                    (clk_i),
    .arst_n_i                 (arst_n_i),
    .dma_pkt_v_i              (dma_pkt_v_i),
    .dma_pkt_write_not_read_i (dma_pkt_write_not_read_i),
    .dma_pkt_addr_i           (dma_pkt_addr_i),
    .dma_pkt_ready_o          (dma_pkt_ready_o),
    .dma_wdata_v_i            (dma_wdata_v_i),
    .dma_wdata_i              (dma_wdata_i),
    .dma_wdata_ready_o        (dma_wdata_ready_o),
    .dma_rdata_o              (dma_rdata_o),
    .dma_rdata_v_o            (dma_rdata_v_o),
    .dma_rdata_ready_i        (dma_rdata_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic report_and_stop(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      report_and_stop($sformatf("CHECK FAILED at %0d ns: %s, got %h, expected %h",
                                $time, what, got, exp));
    end
  endtask

  task automatic abort_timeout(input string what);
    report_and_stop($sformatf("timeout at %0d ns while waiting for %s", $time, what));
  endtask

  // a word lives at channel address {cache id, block, word}, and reads back as written
  function automatic int mem_key(input int c, input logic [BLOCK_IDX_WIDTH-1:0] blk,
                                 input int w);
    return (c << (BLOCK_IDX_WIDTH + WORD_OFFSET_WIDTH)) | (int'(blk) << WORD_OFFSET_WIDTH) | w;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] ref_word(input int c,
                                                     input logic [BLOCK_IDX_WIDTH-1:0] blk,
                                                     input int w);
    if (ref_mem.exists(mem_key(c, blk, w))) begin
      return ref_mem[mem_key(c, blk, w)];
    end
    return 'x;
  endfunction

  task automatic check_idle(input string phase);
    check_value({phase, ": packet ready"}, 32'(dma_pkt_ready_o), '0);
    check_value({phase, ": write data ready"}, 32'(dma_wdata_ready_o), '0);
    check_value({phase, ": read valid"}, 32'(dma_rdata_v_o), '0);
  endtask

  // entered and left on a falling edge
  task automatic issue_packet(input int c, input bit wr, input logic [BLOCK_IDX_WIDTH-1:0] blk);
    int cycles;
    cycles = 0;
    dma_pkt_v_i[c] = 1'b1;
    dma_pkt_write_not_read_i[c] = wr;
    // junk in the low bits, which the arbiter drops
    dma_pkt_addr_i[c] = {blk, 4'($urandom)};
    #SAMPLE_DELAY;
    while (!dma_pkt_ready_o[c]) begin
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_timeout($sformatf("a packet grant on cache %0d", c));
      end
      @(negedge clk_i);
      #SAMPLE_DELAY;
    end
    if (!wr) begin
      for (int w = 0; w < BLOCK_WORDS; w++) begin
        exp_q[c].push_back(ref_word(c, blk, w));
      end
    end
    @(negedge clk_i);
    dma_pkt_v_i[c] = 1'b0;
  endtask

  task automatic write_block(input int c, input logic [BLOCK_IDX_WIDTH-1:0] blk,
                             input logic [DATA_WIDTH-1:0] base);
    int cycles;
    issue_packet(c, 1'b1, blk);
    for (int w = 0; w < BLOCK_WORDS; w++) begin
      cycles = 0;
      dma_wdata_v_i[c] = 1'b1;
      dma_wdata_i[c] = base + 32'(w) * 32'h0101_0101;
      #SAMPLE_DELAY;
      while (!dma_wdata_ready_o[c]) begin
        cycles++;
        if (cycles > WAIT_LIMIT) begin
          abort_timeout($sformatf("write data ready on cache %0d", c));
        end
        @(negedge clk_i);
        #SAMPLE_DELAY;
      end
      ref_mem[mem_key(c, blk, w)] = dma_wdata_i[c];
      @(negedge clk_i);
    end
    dma_wdata_v_i[c] = 1'b0;
  endtask

  task automatic run_job(input int c, input int kind);
    logic [BLOCK_IDX_WIDTH-1:0] blk;
    case (kind)
      JOB_SAME_WRITE: write_block(c, SHARED_BLOCK, {8'ha5, 8'(c), 16'h0});
      JOB_SAME_READ: issue_packet(c, 1'b0, SHARED_BLOCK);
      JOB_FAIR: begin
        for (int n = 0; n < FAIR_PACKETS; n++) begin
          write_block(c, BLOCK_IDX_WIDTH'($urandom), $urandom);
        end
      end
      default: begin
        for (int n = 0; n < RANDOM_ROUNDS; n++) begin
          blk = BLOCK_IDX_WIDTH'($urandom);
          write_block(c, blk, $urandom);
          issue_packet(c, 1'b0, blk);
        end
      end
    endcase
    jobs_running--;
  endtask

  task automatic start_jobs(input int kind);
    for (int i = 0; i < NUM_CACHES; i++) begin
      jobs_running++;
      fork
        automatic int c = i;
        run_job(c, kind);
      join_none
    end
  endtask

  task automatic wait_jobs(input string what);
    int cycles;
    cycles = 0;
    while (jobs_running != 0) begin
      cycles++;
      if (cycles > JOB_LIMIT) begin
        abort_timeout(what);
      end
      @(negedge clk_i);
    end
  endtask

  task automatic wait_reads_drained();
    int cycles;
    int pending;
    cycles = 0;
    pending = 1;
    while (pending != 0) begin
      pending = 0;
      for (int c = 0; c < NUM_CACHES; c++) begin
        pending += exp_q[c].size();
      end
      cycles++;
      if (cycles > JOB_LIMIT) begin
        abort_timeout("outstanding read words");
      end
      @(negedge clk_i);
    end
  endtask

  // between two grants to one cache every other cache gets exactly one
  task automatic note_grant(input int g);
    if (rr_granted[g]) begin
      for (int k = 0; k < NUM_CACHES; k++) begin
        if (k != g) begin
          check_value($sformatf("grants to cache %0d between two grants to cache %0d", k, g),
                      rr_seen[g][k], 1);
        end
      end
    end
    rr_granted[g] = 1'b1;
    rr_grants++;
    for (int k = 0; k < NUM_CACHES; k++) begin
      rr_seen[g][k] = 0;
      if (k != g) begin
        rr_seen[k][g]++;
      end
    end
  endtask

  always begin
    @(negedge clk_i);
    #SAMPLE_DELAY;
    if (!rr_check_en) begin
      rr_grants = 0;
      for (int k = 0; k < NUM_CACHES; k++) begin
        rr_granted[k] = 1'b0;
        for (int j = 0; j < NUM_CACHES; j++) begin
          rr_seen[k][j] = 0;
        end
      end
    end else begin
      for (int g = 0; g < NUM_CACHES; g++) begin
        if (dma_pkt_v_i[g] && dma_pkt_ready_o[g]) begin
          note_grant(g);
        end
      end
    end
  end

  // compare each accepted read beat with the oldest expected word of its cache
  for (genvar g = 0; g < NUM_CACHES; g++) begin : g_cmp
    always begin
      @(negedge clk_i);
      #SAMPLE_DELAY;
      if (arst_n_i && dma_rdata_v_o[g] && dma_rdata_ready_i[g]) begin
        if (exp_q[g].size() == 0) begin
          report_and_stop($sformatf("read word arrived on cache %0d with no read outstanding", g));
        end
        check_value($sformatf("read word on cache %0d", g), dma_rdata_o[g], exp_q[g].pop_front());
      end
    end
  end

  initial begin
    void'($urandom(18581));
    arst_n_i = 1'b0;
    // requests held during reset must not be granted
    dma_pkt_v_i = '1;
    dma_pkt_write_not_read_i = '0;
    dma_pkt_addr_i = '0;
    dma_wdata_v_i = '0;
    dma_wdata_i = '0;
    dma_rdata_ready_i = '1;
    jobs_running = 0;
    bp_run = 1'b0;
    rr_check_en = 1'b0;

    repeat (RESET_CYCLES) begin
      @(negedge clk_i);
      #SAMPLE_DELAY;
      check_idle("during reset");
    end
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #SAMPLE_DELAY;
    check_idle("after reset");
    @(negedge clk_i);
    dma_pkt_v_i = '0;
    #SAMPLE_DELAY;
    check_idle("after reset");
    @(negedge clk_i);

    write_block(1, 8'h05, 32'h1234_5678);
    issue_packet(1, 1'b0, 8'h05);
    wait_reads_drained();

    start_jobs(JOB_SAME_WRITE);
    wait_jobs("writes to the shared block");
    start_jobs(JOB_SAME_READ);
    wait_jobs("reads of the shared block");
    wait_reads_drained();

    rr_check_en = 1'b1;
    start_jobs(JOB_FAIR);
    wait_jobs("continuous write traffic");
    check_value("number of grants seen", rr_grants, NUM_CACHES * FAIR_PACKETS);
    rr_check_en = 1'b0;

    // random read stalls while traffic spreads over rows and banks
    bp_run = 1'b1;
    start_jobs(JOB_RANDOM);
    fork
      begin
        wait_jobs("random traffic");
        bp_run = 1'b0;
      end
      begin : stall_reads
        int cycles;
        cycles = 0;
        while (bp_run && cycles < JOB_LIMIT + 2) begin
          cycles++;
          @(negedge clk_i);
          dma_rdata_ready_i = NUM_CACHES'($urandom);
        end
        dma_rdata_ready_i = '1;
      end
    join
    wait_reads_drained();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
